// File: hdl/elevator_pkg.sv
// Shared types and sizes for the elevator floor-request logic.
// Every design module imports this package in its header.

`default_nettype none

package elevator_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int NUM_FLOORS  = 11;
    localparam int FLOOR_W     = 4;
    // One slot per floor covers the ten floors that can ever be pending
    localparam int STACK_DEPTH = 11;

    //////////////////////////////
    // Basic types
    //////////////////////////////

    // Floor 0 is the lowest landing
    typedef logic [FLOOR_W-1:0]    floor_t;

    // One bit per floor for buttons and lamps
    typedef logic [NUM_FLOORS-1:0] floor_mask_t;

    // State reported by the car controller
    typedef enum logic [1:0] {
        CAR_STOPPED     = 2'd0,
        CAR_MOVING_UP   = 2'd1,
        CAR_MOVING_DOWN = 2'd2,
        CAR_EMERGENCY   = 2'd3
    } car_state_e;

    // Operating mode decoded from power switch and emergency button
    typedef enum logic [1:0] {
        MODE_OFF       = 2'd0,
        MODE_EMERGENCY = 2'd1,
        MODE_NORMAL    = 2'd2
    } op_mode_e;

    //////////////////////////////
    // Bundles
    //////////////////////////////

    typedef struct packed {
        car_state_e state;
        floor_t     floor;
    } car_status_t;

    // Push request into the stack, also used for the stack top
    typedef struct packed {
        logic   valid;
        floor_t floor;
    } floor_req_t;

    // Command toward the car controller
    typedef struct packed {
        logic   activate;
        logic   direction_up;
        floor_t target;
    } dispatch_t;

endpackage

`default_nettype wire

// File: hdl/button_capture.sv
// Input side of the floor-request logic.
// Decodes the operating mode, accepts at most one button press per cycle,
// keeps the panel and call lamps and issues push requests to the stack.

`timescale 1ns/1ps
`default_nettype none

module button_capture import elevator_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset_n,
    input  wire floor_mask_t floor_call_buttons,
    input  wire floor_mask_t panel_buttons,
    input  wire logic        emergency_btn,
    input  wire logic        power_switch,
    input  wire car_status_t car_status,
    output op_mode_e         mode,
    output floor_req_t       push,
    output logic             arrival,
    output floor_mask_t      call_button_lights,
    output floor_mask_t      panel_button_lights
);

    floor_mask_t cur_mask;
    floor_mask_t panel_cand;
    floor_mask_t call_cand;
    floor_mask_t panel_pick;
    floor_mask_t call_pick;
    logic        other_lit;

    // Isolate the lowest set bit
    function automatic floor_mask_t lowest_bit(input floor_mask_t m);
        return m & (~m + floor_mask_t'(1));
    endfunction

    // One-hot floor mask to floor number
    function automatic floor_t mask_to_floor(input floor_mask_t onehot);
        floor_t f;
        f = '0;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (onehot[i]) begin
                f = floor_t'(i);
            end
        end
        return f;
    endfunction

    //////////////////////////////
    // Mode and arrival
    //////////////////////////////

    // Power off wins over emergency
    always_comb begin
        if (!power_switch) begin
            mode = MODE_OFF;
        end else if (emergency_btn) begin
            mode = MODE_EMERGENCY;
        end else begin
            mode = MODE_NORMAL;
        end
    end

    assign arrival  = (mode == MODE_NORMAL) && (car_status.state == CAR_STOPPED);
    assign cur_mask = floor_mask_t'(1) << car_status.floor;

    //////////////////////////////
    // Press acceptance
    //////////////////////////////

    // Candidates are unlit buttons away from the current floor
    assign panel_cand = panel_buttons & ~panel_button_lights & ~cur_mask;
    assign call_cand  = floor_call_buttons & ~call_button_lights & ~cur_mask;

    always_comb begin
        panel_pick = '0;
        call_pick  = '0;
        if (mode == MODE_NORMAL) begin
            // Panel bank wins over the call bank
            if (panel_cand != '0) begin
                panel_pick = lowest_bit(panel_cand);
            end else begin
                call_pick = lowest_bit(call_cand);
            end
        end
    end

    // A floor already lit in the other bank is already on the stack
    assign other_lit = ((panel_pick & call_button_lights) != '0) ||
                       ((call_pick & panel_button_lights) != '0);

    assign push.valid = ((panel_pick | call_pick) != '0) && !other_lit;
    assign push.floor = mask_to_floor(panel_pick | call_pick);

    //////////////////////////////
    // Lamps
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (mode != MODE_NORMAL) begin
            panel_button_lights <= '0;
            call_button_lights  <= '0;
        end else if (arrival) begin
            // Served floor goes dark in both banks
            panel_button_lights <= (panel_button_lights | panel_pick) & ~cur_mask;
            call_button_lights  <= (call_button_lights | call_pick) & ~cur_mask;
        end else begin
            panel_button_lights <= panel_button_lights | panel_pick;
            call_button_lights  <= call_button_lights | call_pick;
        end
    end

endmodule

`default_nettype wire

// File: hdl/request_stack.sv
// LIFO store of requested floors.
// Pushes accepted floors, pops the top once the car stands at it,
// and flushes whenever the mode leaves normal operation.

`timescale 1ns/1ps
`default_nettype none

module request_stack import elevator_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset_n,
    input  wire op_mode_e   mode,
    input  wire floor_req_t push,
    input  wire logic       arrival,
    input  wire floor_t     car_floor,
    output floor_req_t      top
);

    // Floor entries, bottom of the stack first
    floor_t entries [STACK_DEPTH];

    // Count of valid entries and index of the next free slot
    logic [$clog2(STACK_DEPTH+1)-1:0] stack_ptr;

    logic do_push;
    logic do_pop;

    //////////////////////////////
    // Top of stack
    //////////////////////////////

    always_comb begin
        top.valid = (stack_ptr != '0);
        top.floor = '0;
        if (top.valid) begin
            top.floor = entries[stack_ptr - 1'b1];
        end
    end

    // The input side never pushes the floor the car stands at
    assign do_pop  = arrival && top.valid && (top.floor == car_floor);
    assign do_push = push.valid;

    //////////////////////////////
    // Pointer
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            stack_ptr <= '0;
        end else if (mode != MODE_NORMAL) begin
            stack_ptr <= '0;
        end else if (do_pop) begin
            stack_ptr <= stack_ptr - 1'b1;
        end else if (do_push) begin
            stack_ptr <= stack_ptr + 1'b1;
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (do_push && !do_pop) begin
            entries[stack_ptr] <= push.floor;
        end
    end

endmodule

`default_nettype wire

// File: hdl/car_dispatcher.sv
// Output side of the floor-request logic.
// Registers the target floor, travel direction and activate level for the
// car controller, together with the emergency flag and door permissions.

`timescale 1ns/1ps
`default_nettype none

module car_dispatcher import elevator_pkg::*; (
    input  wire logic       clock,
    input  wire logic       reset_n,
    input  wire op_mode_e   mode,
    input  wire logic       arrival,
    input  wire floor_req_t top,
    input  wire floor_t     car_floor,
    input  wire logic       door_open_btn,
    input  wire logic       door_close_btn,
    output dispatch_t       dispatch,
    output logic            emergency_active,
    output logic            door_open_allowed,
    output logic            door_close_allowed
);

    logic start_trip;

    // Stopped car with a pending request somewhere else
    assign start_trip = arrival && top.valid && (top.floor != car_floor);

    //////////////////////////////
    // Dispatch
    //////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dispatch <= '{activate: 1'b0, direction_up: 1'b1, target: '0};
        end else if (mode != MODE_NORMAL) begin
            // Park the command at the ground floor heading up
            dispatch <= '{activate: 1'b0, direction_up: 1'b1, target: '0};
        end else if (start_trip) begin
            dispatch.activate     <= 1'b1;
            dispatch.target       <= top.floor;
            dispatch.direction_up <= (top.floor > car_floor);
        end else begin
            // Target and direction keep their last value
            dispatch.activate <= 1'b0;
        end
    end

    //////////////////////////////
    // Flags and doors
    //////////////////////////////

    // Arrival already implies stopped and powered
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            emergency_active   <= 1'b0;
            door_open_allowed  <= 1'b0;
            door_close_allowed <= 1'b0;
        end else begin
            emergency_active   <= (mode == MODE_EMERGENCY);
            door_open_allowed  <= arrival && door_open_btn;
            door_close_allowed <= arrival && door_close_btn;
        end
    end

endmodule

`default_nettype wire

// File: hdl/floor_logic_top.sv
// Top level of the elevator floor-request logic.
// Connects button capture, request stack and car dispatcher.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_top import elevator_pkg::*; (
    input  wire logic        clock,
    input  wire logic        reset_n,
    input  wire floor_mask_t floor_call_buttons,
    input  wire floor_mask_t panel_buttons,
    input  wire logic        door_open_btn,
    input  wire logic        door_close_btn,
    input  wire logic        emergency_btn,
    input  wire logic        power_switch,
    input  wire car_status_t car_status,
    output dispatch_t        dispatch,
    output logic             emergency_active,
    output logic             door_open_allowed,
    output logic             door_close_allowed,
    output floor_mask_t      call_button_lights,
    output floor_mask_t      panel_button_lights
);

    op_mode_e   mode;
    floor_req_t push;
    floor_req_t top;
    logic       arrival;

    button_capture button_capture_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_status          (car_status),
        .mode                (mode),
        .push                (push),
        .arrival             (arrival),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_stack request_stack_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .mode      (mode),
        .push      (push),
        .arrival   (arrival),
        .car_floor (car_status.floor),
        .top       (top)
    );

    car_dispatcher car_dispatcher_inst (
        .clock              (clock),
        .reset_n            (reset_n),
        .mode               (mode),
        .arrival            (arrival),
        .top                (top),
        .car_floor          (car_status.floor),
        .door_open_btn      (door_open_btn),
        .door_close_btn     (door_close_btn),
        .dispatch           (dispatch),
        .emergency_active   (emergency_active),
        .door_open_allowed  (door_open_allowed),
        .door_close_allowed (door_close_allowed)
    );

endmodule

`default_nettype wire

// File: bench/floor_logic_assert.sv
// Concurrent checks on the request stack.
// Attached to every request_stack instance by the bind at the end.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_assert import elevator_pkg::*; (
    input wire logic                             clock,
    input wire logic                             reset_n,
    input wire op_mode_e                         mode,
    input wire floor_req_t                       push,
    input wire floor_t                           car_floor,
    input wire logic [$clog2(STACK_DEPTH+1)-1:0] stack_ptr
);

    // Count of failed assertions
    int assert_errors;

    initial assert_errors = 0;

    pointer_in_range: assert property (@(posedge clock) disable iff (!reset_n)
        int'(stack_ptr) <= STACK_DEPTH)
    else begin
        $error("stack pointer %0d exceeds the stack depth", stack_ptr);
        assert_errors++;
    end

    // Off and emergency flush the whole stack at the next edge
    flush_outside_normal: assert property (@(posedge clock) disable iff (!reset_n)
        (mode != MODE_NORMAL) |=> (stack_ptr == '0))
    else begin
        $error("stack not empty one cycle after leaving normal mode");
        assert_errors++;
    end

    push_away_from_car: assert property (@(posedge clock) disable iff (!reset_n)
        push.valid |-> (push.floor != car_floor))
    else begin
        $error("push of floor %0d while the car stands there", push.floor);
        assert_errors++;
    end

endmodule

bind request_stack floor_logic_assert stack_checks (
    .clock     (clock),
    .reset_n   (reset_n),
    .mode      (mode),
    .push      (push),
    .car_floor (car_floor),
    .stack_ptr (stack_ptr)
);

`default_nettype wire

// File: bench/floor_logic_tb.sv
// Testbench for the elevator floor-request logic.
// Reads input steps and expected outputs from the vectors file, holds each
// step for three clock cycles and then checks lights, dispatch, flag and doors.

`timescale 1ns/1ps
`default_nettype none

module floor_logic_tb import elevator_pkg::*; ();

    localparam int    CLK_PERIOD    = 100;
    localparam int    DRIVE_DELAY   = 5;
    localparam int    RESET_CYCLES  = 4;
    localparam int    STEP_CYCLES   = 3;
    localparam int    MARGIN_CYCLES = 20;
    localparam string VECTOR_FILE   = "bench/floor_logic_vectors.txt";

    // One line of the vectors file
    typedef struct packed {
        int          test;
        floor_mask_t call_btn;
        floor_mask_t panel_btn;
        logic        door_open;
        logic        door_close;
        logic        emergency;
        logic        power;
        car_status_t status;
        floor_mask_t exp_call;
        floor_mask_t exp_panel;
        dispatch_t   exp_dispatch;
        logic        exp_emergency;
        logic        exp_door_open;
        logic        exp_door_close;
    } vector_t;

    logic        clock;
    logic        reset_n;
    floor_mask_t floor_call_buttons;
    floor_mask_t panel_buttons;
    logic        door_open_btn;
    logic        door_close_btn;
    logic        emergency_btn;
    logic        power_switch;
    car_status_t car_status;
    dispatch_t   dispatch;
    logic        emergency_active;
    logic        door_open_allowed;
    logic        door_close_allowed;
    floor_mask_t call_button_lights;
    floor_mask_t panel_button_lights;

    vector_t vectors[$];
    logic    vectors_ready;
    int      error_count;
    int      test_errors;

    floor_logic_top floor_logic_top_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .door_open_btn       (door_open_btn),
        .door_close_btn      (door_close_btn),
        .emergency_btn       (emergency_btn),
        .power_switch        (power_switch),
        .car_status          (car_status),
        .dispatch            (dispatch),
        .emergency_active    (emergency_active),
        .door_open_allowed   (door_open_allowed),
        .door_close_allowed  (door_close_allowed),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    //////////////////////////////
    // Vector file
    //////////////////////////////

    task automatic load_vectors();
        int      fd;
        int      n;
        string   line;
        vector_t v;
        int      test, call_m, panel_m, d_open, d_close, emer, pwr, state, floor_n;
        int      x_call, x_panel, x_act, x_up, x_tgt, x_emer, x_open, x_close;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the vector file %s", VECTOR_FILE);
            error_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                // Lines starting with # describe the columns
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                n = $sscanf(line, "%d %h %h %d %d %d %d %d %d %h %h %d %d %d %d %d %d",
                            test, call_m, panel_m, d_open, d_close, emer, pwr, state,
                            floor_n, x_call, x_panel, x_act, x_up, x_tgt, x_emer,
                            x_open, x_close);
                if (n == 17) begin
                    v.test                      = test;
                    v.call_btn                  = floor_mask_t'(call_m);
                    v.panel_btn                 = floor_mask_t'(panel_m);
                    v.door_open                 = d_open[0];
                    v.door_close                = d_close[0];
                    v.emergency                 = emer[0];
                    v.power                     = pwr[0];
                    v.status.state              = car_state_e'(state[1:0]);
                    v.status.floor              = floor_t'(floor_n);
                    v.exp_call                  = floor_mask_t'(x_call);
                    v.exp_panel                 = floor_mask_t'(x_panel);
                    v.exp_dispatch.activate     = x_act[0];
                    v.exp_dispatch.direction_up = x_up[0];
                    v.exp_dispatch.target       = floor_t'(x_tgt);
                    v.exp_emergency             = x_emer[0];
                    v.exp_door_open             = x_open[0];
                    v.exp_door_close            = x_close[0];
                    vectors.push_back(v);
                end else if (n > 0) begin
                    $display("Malformed line in the vector file: %s", line);
                    error_count++;
                end
            end
            $fclose(fd);
        end
        if (vectors.size() == 0) begin
            $display("The vector file holds no steps");
            error_count++;
        end
    endtask

    task automatic drive_inputs(input vector_t v);
        floor_call_buttons = v.call_btn;
        panel_buttons      = v.panel_btn;
        door_open_btn      = v.door_open;
        door_close_btn     = v.door_close;
        emergency_btn      = v.emergency;
        power_switch       = v.power;
        car_status         = v.status;
    endtask

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic check_lights(input string what, input floor_mask_t got,
                                input floor_mask_t exp, input int test);
        if (got !== exp) begin
            $display("FAIL %0d ns: test %0d, %s lights are %h, expected %h",
                     $time, test, what, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic compare_dispatch(input dispatch_t got, input dispatch_t exp,
                                    input int test);
        if (got !== exp) begin
            $display("FAIL %0d ns: test %0d, dispatch act/up/target %b/%b/%0d, expected %b/%b/%0d",
                     $time, test, got.activate, got.direction_up, got.target,
                     exp.activate, exp.direction_up, exp.target);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic expect_bit(input string what, input logic got, input logic exp,
                              input int test);
        if (got !== exp) begin
            $display("FAIL %0d ns: test %0d, %s is %b, expected %b",
                     $time, test, what, got, exp);
            error_count++;
            test_errors++;
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        vector_t v;
        int      test_steps;
        int      total_tests;
        int      assert_errors;
        clock              = 1'b0;
        reset_n            = 1'b0;
        floor_call_buttons = '0;
        panel_buttons      = '0;
        door_open_btn      = 1'b0;
        door_close_btn     = 1'b0;
        emergency_btn      = 1'b0;
        power_switch       = 1'b1;
        car_status         = '{state: CAR_STOPPED, floor: '0};
        vectors_ready      = 1'b0;
        error_count        = 0;
        test_errors        = 0;
        test_steps         = 0;
        total_tests        = 0;
        load_vectors();
        vectors_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        reset_n = 1'b1;

        // Each step starts DRIVE_DELAY after a rising edge
        foreach (vectors[i]) begin
            v = vectors[i];
            drive_inputs(v);
            repeat (STEP_CYCLES) @(posedge clock);
            #1;
            check_lights("call", call_button_lights, v.exp_call, v.test);
            check_lights("panel", panel_button_lights, v.exp_panel, v.test);
            compare_dispatch(dispatch, v.exp_dispatch, v.test);
            expect_bit("emergency_active", emergency_active, v.exp_emergency, v.test);
            expect_bit("door_open_allowed", door_open_allowed, v.exp_door_open, v.test);
            expect_bit("door_close_allowed", door_close_allowed, v.exp_door_close, v.test);
            test_steps++;
            if (i == vectors.size() - 1 || vectors[i + 1].test != v.test) begin
                $display("test %0d %s: %0d steps, %0d mismatches", v.test,
                         (test_errors == 0) ? "passed" : "failed", test_steps, test_errors);
                total_tests++;
                test_steps  = 0;
                test_errors = 0;
            end
            #(DRIVE_DELAY - 1);
        end

        assert_errors = floor_logic_top_inst.request_stack_inst.stack_checks.assert_errors;
        $display("Summary: %0d tests, %0d steps, %0d mismatches, %0d assertion failures",
                 total_tests, vectors.size(), error_count, assert_errors);
        if (error_count == 0 && assert_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog sized from the number of steps
    initial begin
        time limit;
        wait (vectors_ready);
        limit = (vectors.size() * STEP_CYCLES + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("Timeout: the run did not finish within %0d ns", limit);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/floor_logic_vectors.txt
# test call panel dopen dclose emerg power state floor | call_lt panel_lt act up target emerg_act dopen_ok dclose_ok
# masks are hex, one bit per floor; state 0 stopped, 1 up, 2 down, 3 emergency; other fields decimal
# press at floor 0 and dispatch upward
1 000 000 0 0 0 1 0 0   000 000 0 1 0  0 0 0
1 000 020 0 0 0 1 0 0   000 020 1 1 5  0 0 0
# duplicate call, then LIFO order at floor 4
2 000 008 0 0 0 1 0 4   000 028 1 0 3  0 0 0
2 008 000 0 0 0 1 0 4   008 028 1 0 3  0 0 0
2 000 100 0 0 0 1 0 4   008 128 1 1 8  0 0 0
2 000 004 0 0 0 1 0 4   008 12c 1 0 2  0 0 0
# travel, arrival pop, press at the current floor
3 000 000 0 0 0 1 2 3   008 12c 0 0 2  0 0 0
3 000 000 0 0 0 1 0 2   008 128 1 1 8  0 0 0
3 004 004 0 0 0 1 0 2   008 128 1 1 8  0 0 0
# press while moving, then serve the stack down
4 000 040 0 0 0 1 1 5   008 168 0 1 8  0 0 0
4 000 000 0 0 0 1 0 7   008 168 1 0 6  0 0 0
4 000 000 0 0 0 1 0 6   008 128 1 1 8  0 0 0
4 000 000 0 0 0 1 0 8   008 028 1 0 3  0 0 0
4 000 000 0 0 0 1 0 3   000 020 1 1 5  0 0 0
# emergency and power-off flush
5 080 000 0 0 0 1 0 3   080 020 1 1 7  0 0 0
5 000 010 1 0 1 1 3 3   000 000 0 1 0  1 0 0
5 000 000 0 0 0 1 0 3   000 000 0 1 0  0 0 0
5 000 200 0 0 0 1 0 3   000 200 1 1 9  0 0 0
5 000 002 0 0 1 0 0 3   000 000 0 1 0  0 0 0
5 000 000 0 0 0 1 0 3   000 000 0 1 0  0 0 0
# door permissions
6 000 000 1 0 0 1 0 3   000 000 0 1 0  0 1 0
6 000 000 0 1 0 1 0 3   000 000 0 1 0  0 0 1
6 000 000 1 1 0 1 1 4   000 000 0 1 0  0 0 0
6 000 000 0 1 1 1 3 4   000 000 0 1 0  1 0 0
6 000 000 1 0 0 0 0 4   000 000 0 1 0  0 0 0
6 000 000 1 1 0 1 0 4   000 000 0 1 0  0 1 1

// File: project.f
hdl/elevator_pkg.sv
hdl/button_capture.sv
hdl/request_stack.sv
hdl/car_dispatcher.sv
hdl/floor_logic_top.sv
bench/floor_logic_assert.sv
bench/floor_logic_tb.sv

// File: Makefile
BUILD := obj_dir

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module floor_logic_tb --Mdir $(BUILD) -o floor_logic_sim
	./$(BUILD)/floor_logic_sim | tee sim.log
	grep -q ">>> PASS" sim.log

clean:
	rm -rf $(BUILD) sim.log
